// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pipelined_add_sub
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
rtl/add_sub_pkg.sv
rtl/operand_stage.sv
rtl/group_pg_stage.sv
rtl/carry_sum_stage.sv
rtl/pipelined_add_sub.sv
test/add_sub_checker.sv
test/tb_pipelined_add_sub.sv

// ==== rtl/add_sub_pkg.sv ====
/* Adder/subtractor shared types */

`default_nettype none

package add_sub_pkg;

  // Operation select, one bit on the wire
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } op_e;

  // Operand width in bits
  parameter int DEFAULT_WIDTH = 32;

  // Lookahead group size, must divide the width
  parameter int DEFAULT_GROUP = 4;

endpackage

`default_nettype wire

// ==== rtl/carry_sum_stage.sv ====
/* Carry resolve and sum stage */

`timescale 1ns/100ps
`default_nettype none

module carry_sum_stage #(
  parameter int WIDTH = add_sub_pkg::DEFAULT_WIDTH,
  parameter int GROUP = add_sub_pkg::DEFAULT_GROUP
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [WIDTH-1:0]         p_bits_q,
  input  logic [WIDTH-1:0]         g_bits_q,
  input  logic [WIDTH/GROUP-1:0]   group_p,
  input  logic [WIDTH/GROUP-1:0]   group_g,
  input  logic                     cin_q,
  input  logic                     msb_a_q,
  input  logic                     msb_b_eff_q,
  input  logic                     s2_valid,
  output logic [WIDTH-1:0]         sum,
  output logic                     carry_out,
  output logic                     overflow,
  output logic                     out_valid
);

  localparam int NGROUPS = WIDTH / GROUP;

  logic [NGROUPS:0]   grp_c;
  logic [WIDTH-1:0]   bit_c;
  logic [WIDTH-1:0]   sum_next;
  logic               ovf_next;

  // Carry into each group from the lookahead chain
  always_comb begin
    grp_c[0] = cin_q;
    for (int j = 0; j < NGROUPS; j++) begin
      grp_c[j+1] = group_g[j] | (group_p[j] & grp_c[j]);
    end
  end

  // Expand the group carry-in across the bits of that group
  always_comb begin : expand_carry
    logic c;
    for (int j = 0; j < NGROUPS; j++) begin
      c = grp_c[j];
      for (int k = 0; k < GROUP; k++) begin
        bit_c[j*GROUP + k] = c;
        c = g_bits_q[j*GROUP + k] | (p_bits_q[j*GROUP + k] & c);
      end
    end
  end

  assign sum_next = p_bits_q ^ bit_c;

  // Same-sign operands with a flipped result sign
  assign ovf_next = (msb_a_q == msb_b_eff_q) && (sum_next[WIDTH-1] != msb_a_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      sum       <= sum_next;
      // Top group carry; for subtract a one means no borrow
      carry_out <= grp_c[NGROUPS];
      overflow  <= ovf_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/group_pg_stage.sv ====
/* Group propagate/generate stage */

`timescale 1ns/100ps
`default_nettype none

module group_pg_stage #(
  parameter int WIDTH = add_sub_pkg::DEFAULT_WIDTH,
  parameter int GROUP = add_sub_pkg::DEFAULT_GROUP
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [WIDTH-1:0]         p_bits,
  input  logic [WIDTH-1:0]         g_bits,
  input  logic                     cin,
  input  logic                     msb_a,
  input  logic                     msb_b_eff,
  input  logic                     s1_valid,
  output logic [WIDTH-1:0]         p_bits_q,
  output logic [WIDTH-1:0]         g_bits_q,
  output logic [WIDTH/GROUP-1:0]   group_p,
  output logic [WIDTH/GROUP-1:0]   group_g,
  output logic                     cin_q,
  output logic                     msb_a_q,
  output logic                     msb_b_eff_q,
  output logic                     s2_valid
);

  localparam int NGROUPS = WIDTH / GROUP;

  logic [NGROUPS-1:0] gp_next;
  logic [NGROUPS-1:0] gg_next;

  // Group P is all bits propagating; group G folds generates upward
  always_comb begin : reduce_pg
    logic gg;
    for (int j = 0; j < NGROUPS; j++) begin
      gp_next[j] = &p_bits[j*GROUP +: GROUP];
      gg = g_bits[j*GROUP];
      for (int k = 1; k < GROUP; k++) begin
        gg = g_bits[j*GROUP + k] | (p_bits[j*GROUP + k] & gg);
      end
      gg_next[j] = gg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  // Bit-level p/g ride along for the in-group carry expansion
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      p_bits_q    <= p_bits;
      g_bits_q    <= g_bits;
      group_p     <= gp_next;
      group_g     <= gg_next;
      cin_q       <= cin;
      msb_a_q     <= msb_a;
      msb_b_eff_q <= msb_b_eff;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/operand_stage.sv ====
/* Operand stage of the CLA pipeline */

`timescale 1ns/100ps
`default_nettype none

module operand_stage #(
  parameter int WIDTH = add_sub_pkg::DEFAULT_WIDTH,
  parameter int GROUP = add_sub_pkg::DEFAULT_GROUP
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  input  add_sub_pkg::op_e   op,
  output logic [WIDTH-1:0]   p_bits,
  output logic [WIDTH-1:0]   g_bits,
  output logic               cin,
  output logic               msb_a,
  output logic               msb_b_eff,
  output logic               s1_valid
);

  localparam int NGROUPS = WIDTH / GROUP;

  logic             is_sub;
  logic [WIDTH-1:0] b_eff;
  logic [WIDTH-1:0] p_next;
  logic [WIDTH-1:0] g_next;

  // Subtract is a + ~b + 1
  assign is_sub = (op == add_sub_pkg::OP_SUB);
  assign b_eff  = is_sub ? ~b : b;

  // Bitwise propagate and generate, laid out per lookahead group
  for (genvar gi = 0; gi < NGROUPS; gi++) begin : g_slice
    assign p_next[gi*GROUP +: GROUP] = a[gi*GROUP +: GROUP] ^ b_eff[gi*GROUP +: GROUP];
    assign g_next[gi*GROUP +: GROUP] = a[gi*GROUP +: GROUP] & b_eff[gi*GROUP +: GROUP];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Payload only loads with a valid item
  always_ff @(posedge clk) begin
    if (in_valid) begin
      p_bits    <= p_next;
      g_bits    <= g_next;
      cin       <= is_sub;
      msb_a     <= a[WIDTH-1];
      msb_b_eff <= b_eff[WIDTH-1];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pipelined_add_sub.sv ====
/* Pipelined CLA adder/subtractor */

`timescale 1ns/100ps
`default_nettype none

module pipelined_add_sub #(
  parameter int WIDTH = add_sub_pkg::DEFAULT_WIDTH,
  parameter int GROUP = add_sub_pkg::DEFAULT_GROUP
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  input  add_sub_pkg::op_e   op,
  output logic [WIDTH-1:0]   sum,
  output logic               carry_out,
  output logic               overflow,
  output logic               out_valid
);

  localparam int NGROUPS = WIDTH / GROUP;

  // Stage 1 outputs
  logic [WIDTH-1:0]   s1_p_bits;
  logic [WIDTH-1:0]   s1_g_bits;
  logic               s1_cin;
  logic               s1_msb_a;
  logic               s1_msb_b_eff;
  logic               s1_valid;

  // Stage 2 outputs
  logic [WIDTH-1:0]   s2_p_bits;
  logic [WIDTH-1:0]   s2_g_bits;
  logic [NGROUPS-1:0] s2_group_p;
  logic [NGROUPS-1:0] s2_group_g;
  logic               s2_cin;
  logic               s2_msb_a;
  logic               s2_msb_b_eff;
  logic               s2_valid;

  operand_stage #(
    .WIDTH (WIDTH),
    .GROUP (GROUP)
  ) u_operand_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .op        (op),
    .p_bits    (s1_p_bits),
    .g_bits    (s1_g_bits),
    .cin       (s1_cin),
    .msb_a     (s1_msb_a),
    .msb_b_eff (s1_msb_b_eff),
    .s1_valid  (s1_valid)
  );

  group_pg_stage #(
    .WIDTH (WIDTH),
    .GROUP (GROUP)
  ) u_group_pg_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .p_bits      (s1_p_bits),
    .g_bits      (s1_g_bits),
    .cin         (s1_cin),
    .msb_a       (s1_msb_a),
    .msb_b_eff   (s1_msb_b_eff),
    .s1_valid    (s1_valid),
    .p_bits_q    (s2_p_bits),
    .g_bits_q    (s2_g_bits),
    .group_p     (s2_group_p),
    .group_g     (s2_group_g),
    .cin_q       (s2_cin),
    .msb_a_q     (s2_msb_a),
    .msb_b_eff_q (s2_msb_b_eff),
    .s2_valid    (s2_valid)
  );

  carry_sum_stage #(
    .WIDTH (WIDTH),
    .GROUP (GROUP)
  ) u_carry_sum_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .p_bits_q    (s2_p_bits),
    .g_bits_q    (s2_g_bits),
    .group_p     (s2_group_p),
    .group_g     (s2_group_g),
    .cin_q       (s2_cin),
    .msb_a_q     (s2_msb_a),
    .msb_b_eff_q (s2_msb_b_eff),
    .s2_valid    (s2_valid),
    .sum         (sum),
    .carry_out   (carry_out),
    .overflow    (overflow),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

// ==== test/add_sub_checker.sv ====
/* End-to-end result checker */

`timescale 1ns/100ps
`default_nettype none

module add_sub_checker #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  input  add_sub_pkg::op_e   op,
  input  logic [WIDTH-1:0]   sum,
  input  logic               carry_out,
  input  logic               overflow,
  input  logic               out_valid,
  output logic               ref_valid,
  output logic [WIDTH-1:0]   ref_sum,
  output int                 xz_errors
);

  logic [2:0]       v_d;
  logic [WIDTH-1:0] a_d [3];
  logic [WIDTH-1:0] b_d [3];
  add_sub_pkg::op_e op_d [3];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v_d <= '0;
    end else begin
      v_d <= {v_d[1:0], in_valid};
    end
  end

  // Same three-deep delay as the DUT
  always_ff @(posedge clk) begin
    a_d[0]  <= a;
    b_d[0]  <= b;
    op_d[0] <= op;
    for (int i = 1; i < 3; i++) begin
      a_d[i]  <= a_d[i-1];
      b_d[i]  <= b_d[i-1];
      op_d[i] <= op_d[i-1];
    end
  end

  assign ref_valid = v_d[2];
  // Wrap-around result of the oldest captured item
  assign ref_sum = (op_d[2] == add_sub_pkg::OP_SUB) ? a_d[2] - b_d[2] : a_d[2] + b_d[2];

  // Outputs are stable between edges
  always @(negedge clk) begin
    if (rst_n && $isunknown(out_valid)) begin
      xz_errors++;
      $display("Checker: out_valid is X or Z at time %0t", $time);
    end else if (out_valid === 1'b1 && $isunknown({sum, carry_out, overflow})) begin
      xz_errors++;
      $display("Checker: result outputs hold X or Z while out_valid is high at %0t", $time);
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_pipelined_add_sub.sv ====
/* Pipelined adder/subtractor testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_pipelined_add_sub;

  localparam int WIDTH        = 32;
  localparam int GROUP        = 4;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = 3;
  localparam int NUM_RANDOM   = 24;

  typedef struct {
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    add_sub_pkg::op_e op;
    logic [WIDTH-1:0] sum;
    logic             cout;
    logic             ovf;
    int               gap;
  } row_t;

  typedef struct {
    int               row;
    int               entry_cycle;
    logic [WIDTH-1:0] sum;
    logic             cout;
    logic             ovf;
  } pending_t;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  add_sub_pkg::op_e op;
  logic [WIDTH-1:0] sum;
  logic             carry_out;
  logic             overflow;
  logic             out_valid;
  logic             ref_valid;
  logic [WIDTH-1:0] ref_sum;
  int               xz_errors;

  row_t     rows[$];
  pending_t pending[$];
  int       errors      = 0;
  int       checked     = 0;
  int       cycle_count = 0;
  int       cycle_limit = 0;

  pipelined_add_sub #(
    .WIDTH (WIDTH),
    .GROUP (GROUP)
  ) i_pipelined_add_sub (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .op        (op),
    .sum       (sum),
    .carry_out (carry_out),
    .overflow  (overflow),
    .out_valid (out_valid)
  );

  add_sub_checker #(
    .WIDTH (WIDTH)
  ) i_add_sub_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .op        (op),
    .sum       (sum),
    .carry_out (carry_out),
    .overflow  (overflow),
    .out_valid (out_valid),
    .ref_valid (ref_valid),
    .ref_sum   (ref_sum),
    .xz_errors (xz_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_value(input string name, input logic [WIDTH-1:0] expected,
                             input logic [WIDTH-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic add_row(input logic [WIDTH-1:0] ra, input logic [WIDTH-1:0] rb,
                         input add_sub_pkg::op_e rop, input logic [WIDTH-1:0] rsum,
                         input logic rcout, input logic rovf, input int rgap);
    row_t r;
    r.a    = ra;
    r.b    = rb;
    r.op   = rop;
    r.sum  = rsum;
    r.cout = rcout;
    r.ovf  = rovf;
    r.gap  = rgap;
    rows.push_back(r);
  endtask

  // Expected values from a + b_eff + cin and the sign rule
  task automatic add_random_row(input int rgap);
    logic [WIDTH-1:0] ra;
    logic [WIDTH-1:0] rb;
    logic [WIDTH-1:0] b_eff;
    logic [WIDTH:0]   full;
    logic             rovf;
    add_sub_pkg::op_e rop;
    ra    = $urandom();
    rb    = $urandom();
    rop   = ($urandom() % 2 == 1) ? add_sub_pkg::OP_SUB : add_sub_pkg::OP_ADD;
    b_eff = (rop == add_sub_pkg::OP_SUB) ? ~rb : rb;
    full  = {1'b0, ra} + {1'b0, b_eff} + (WIDTH+1)'(rop == add_sub_pkg::OP_SUB);
    rovf  = (ra[WIDTH-1] == b_eff[WIDTH-1]) && (full[WIDTH-1] != ra[WIDTH-1]);
    add_row(ra, rb, rop, full[WIDTH-1:0], full[WIDTH], rovf, rgap);
  endtask

  task automatic monitor_outputs();
    pending_t e;
    if (ref_valid || out_valid) begin
      check_value("checker valid alignment", WIDTH'(ref_valid), WIDTH'(out_valid));
    end
    if (ref_valid && out_valid === 1'b1) begin
      check_value("checker wrap-around sum", ref_sum, sum);
    end
    if (out_valid === 1'b1) begin
      if (pending.size() == 0) begin
        errors++;
        $display("out_valid went high at cycle %0d with no result pending", cycle_count);
      end else begin
        e = pending.pop_front();
        checked++;
        check_value($sformatf("row %0d latency", e.row), WIDTH'(e.entry_cycle + LATENCY),
                    WIDTH'(cycle_count));
        check_value($sformatf("row %0d sum", e.row), e.sum, sum);
        check_value($sformatf("row %0d carry_out", e.row), WIDTH'(e.cout), WIDTH'(carry_out));
        check_value($sformatf("row %0d overflow", e.row), WIDTH'(e.ovf), WIDTH'(overflow));
      end
    end else if (pending.size() > 0 && pending[0].entry_cycle + LATENCY <= cycle_count) begin
      e = pending.pop_front();
      errors++;
      $display("Result for row %0d never appeared on out_valid", e.row);
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    monitor_outputs();
  endtask

  initial begin
    int unsigned seed_value;
    int          total_gaps;
    pending_t    entry;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    op       = add_sub_pkg::OP_ADD;
    seed_value = $urandom(32'hb7a6_6969);

    // a, b, op, sum, carry_out, overflow, idle cycles after
    add_row(32'h0000_0000, 32'h0000_0000, add_sub_pkg::OP_ADD, 32'h0000_0000, 1'b0, 1'b0, 0);
    add_row(32'hffff_ffff, 32'h0000_0001, add_sub_pkg::OP_ADD, 32'h0000_0000, 1'b1, 1'b0, 0);
    add_row(32'haaaa_aaaa, 32'h5555_5555, add_sub_pkg::OP_ADD, 32'hffff_ffff, 1'b0, 1'b0, 2);
    add_row(32'h7fff_ffff, 32'h0000_0001, add_sub_pkg::OP_ADD, 32'h8000_0000, 1'b0, 1'b1, 0);
    add_row(32'h8000_0000, 32'h8000_0000, add_sub_pkg::OP_ADD, 32'h0000_0000, 1'b1, 1'b1, 0);
    add_row(32'h0000_0000, 32'h0000_0001, add_sub_pkg::OP_SUB, 32'hffff_ffff, 1'b0, 1'b0, 0);
    add_row(32'h1234_5678, 32'h1234_5678, add_sub_pkg::OP_SUB, 32'h0000_0000, 1'b1, 1'b0, 1);
    add_row(32'h8000_0000, 32'h0000_0001, add_sub_pkg::OP_SUB, 32'h7fff_ffff, 1'b1, 1'b1, 0);
    add_row(32'h7fff_ffff, 32'hffff_ffff, add_sub_pkg::OP_SUB, 32'h8000_0000, 1'b0, 1'b1, 0);
    add_row(32'h0000_0005, 32'h0000_0003, add_sub_pkg::OP_SUB, 32'h0000_0002, 1'b1, 1'b0, 0);
    add_row(32'hdead_beef, 32'h0123_4567, add_sub_pkg::OP_ADD, 32'hdfd1_0456, 1'b0, 1'b0, 0);
    add_row(32'h0000_0003, 32'h0000_0005, add_sub_pkg::OP_SUB, 32'hffff_fffe, 1'b0, 1'b0, 3);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_random_row(int'($urandom_range(2, 0)));
    end

    total_gaps = 0;
    foreach (rows[i]) total_gaps += rows[i].gap;
    cycle_limit = (rows.size() + total_gaps + LATENCY + RESET_CYCLES) * 2;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("out_valid during reset", '0, WIDTH'(out_valid));
    end
    rst_n = 1'b1;

    foreach (rows[i]) begin
      next_cycle();
      in_valid = 1'b1;
      a        = rows[i].a;
      b        = rows[i].b;
      op       = rows[i].op;
      entry.row         = i;
      entry.entry_cycle = cycle_count;
      entry.sum         = rows[i].sum;
      entry.cout        = rows[i].cout;
      entry.ovf         = rows[i].ovf;
      pending.push_back(entry);
      repeat (rows[i].gap) begin
        next_cycle();
        in_valid = 1'b0;
      end
    end
    next_cycle();
    in_valid = 1'b0;
    // Drain, then watch a few idle cycles for stray strobes
    while (pending.size() > 0) next_cycle();
    repeat (4) next_cycle();

    $display("Summary: %0d results checked, %0d testbench errors, %0d checker X/Z errors",
             checked, errors, xz_errors);
    if (errors == 0 && xz_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    while (cycle_limit == 0 || cycle_count < cycle_limit) @(posedge clk);
    $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
